//--- hw/memory_game_pkg.sv
package memory_game_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Board sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int CARD_COUNT = 12;
    localparam int PAIR_COUNT = 6;
    // Card addresses run 1 to 12, address 0 is not a card
    localparam int ADDR_W     = 4;
    localparam int COLOR_W    = 12;
    localparam int CARD_W     = 14;

    // Card word layout
    localparam int CARD_ACTIVE_BIT = 0;
    localparam int CARD_DISC_BIT   = 1;
    localparam int COLOR_LSB       = 2;

    // Shuffle register start value after reset
    localparam logic [3:0] SHUFFLE_SEED = 4'd8;

    ////////////////////////////////////////////////////////////////////////////
    // Colour table, red in the upper nibble
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [COLOR_W-1:0] COLOR_GREEN   = 12'h0F0;
    localparam logic [COLOR_W-1:0] COLOR_YELLOW  = 12'hFF0;
    localparam logic [COLOR_W-1:0] COLOR_RED     = 12'hF00;
    localparam logic [COLOR_W-1:0] COLOR_BLUE    = 12'h00F;
    localparam logic [COLOR_W-1:0] COLOR_MAGENTA = 12'hF0F;
    localparam logic [COLOR_W-1:0] COLOR_MINT    = 12'h0AA;

    // Index 0 is green, index 5 is mint
    localparam logic [PAIR_COUNT-1:0][COLOR_W-1:0] COLOR_TABLE = {
        COLOR_MINT, COLOR_MAGENTA, COLOR_BLUE, COLOR_RED, COLOR_YELLOW, COLOR_GREEN
    };

    // Control FSM states
    typedef enum logic [2:0] {
        S_IDLE, S_DEAL, S_WAIT_PICK, S_READ, S_RESPOND, S_COVER
    } ctrl_state_t;

    // Result returned with each pick response
    typedef enum logic [1:0] {
        R_FIRST, R_MATCH, R_MISS, R_REJECT
    } pick_result_t;

endpackage

//--- hw/card_deal.sv
`timescale 1ns/1ps

module card_deal (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               deal_start,
    output logic                               deal_wr_en,
    output logic [memory_game_pkg::ADDR_W-1:0] deal_wr_addr,
    output logic [memory_game_pkg::CARD_W-1:0] deal_wr_data,
    output logic                               deal_done
);

    // Shuffle sequence state and its next value
    logic [3:0] shuffle;
    logic [3:0] shuffle_next;
    logic [3:0] value_m1;
    logic [2:0] color_idx;
    logic       value_is_card;
    logic       running;
    logic [memory_game_pkg::ADDR_W-1:0] next_slot;
    logic [memory_game_pkg::COLOR_W-1:0] deal_color;

    ////////////////////////////////////////////////////////////////////////////
    // Shuffle decode
    ////////////////////////////////////////////////////////////////////////////

    // Shift right, new MSB from the two low bits
    assign shuffle_next = {shuffle[0] ^ shuffle[1], shuffle[3:1]};

    // Only values 1 to 12 deal a card
    assign value_is_card = (shuffle != 4'd0) && (shuffle <= memory_game_pkg::CARD_COUNT);

    // Two consecutive values share one colour
    assign value_m1  = shuffle - 4'd1;
    assign color_idx = value_m1[3:1];

    always_comb begin
        deal_color = '0;
        if (value_is_card) begin
            deal_color = memory_game_pkg::COLOR_TABLE[color_idx];
        end
    end

    // Dealt card is active and covered
    always_comb begin
        deal_wr_data = '0;
        deal_wr_data[memory_game_pkg::CARD_W-1:memory_game_pkg::COLOR_LSB] = deal_color;
        deal_wr_data[memory_game_pkg::CARD_ACTIVE_BIT] = 1'b1;
    end

    assign deal_wr_en   = running && value_is_card;
    assign deal_wr_addr = next_slot;

    ////////////////////////////////////////////////////////////////////////////
    // Dealing sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            shuffle   <= memory_game_pkg::SHUFFLE_SEED;
            running   <= 1'b0;
            next_slot <= memory_game_pkg::ADDR_W'(1);
            deal_done <= 1'b0;
        end else begin
            deal_done <= 1'b0;
            if (deal_start) begin
                // Shuffle keeps its value across games
                running   <= 1'b1;
                next_slot <= memory_game_pkg::ADDR_W'(1);
            end else if (running) begin
                shuffle <= shuffle_next;
                if (value_is_card) begin
                    next_slot <= next_slot + 1'b1;
                    // Last slot written, done pulses next cycle
                    if (next_slot == memory_game_pkg::CARD_COUNT) begin
                        running   <= 1'b0;
                        deal_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hw/card_regfile.sv
`timescale 1ns/1ps

module card_regfile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               deal_wr_en,
    input  logic [memory_game_pkg::ADDR_W-1:0] deal_wr_addr,
    input  logic [memory_game_pkg::CARD_W-1:0] deal_wr_data,
    input  logic                               ctrl_wr_en,
    input  logic [memory_game_pkg::ADDR_W-1:0] ctrl_wr_addr,
    input  logic [memory_game_pkg::CARD_W-1:0] ctrl_wr_data,
    input  logic [memory_game_pkg::ADDR_W-1:0] ctrl_rd_addr,
    output logic [memory_game_pkg::CARD_W-1:0] ctrl_rd_data,
    input  logic [memory_game_pkg::ADDR_W-1:0] disp_addr,
    output logic [memory_game_pkg::CARD_W-1:0] disp_data
);

    // One word per card, slot 0 does not exist
    logic [memory_game_pkg::CARD_W-1:0] cards [1:memory_game_pkg::CARD_COUNT];

    logic deal_hit;
    logic ctrl_hit;
    logic ctrl_rd_hit;
    logic disp_hit;

    // Address range checks for every port
    assign deal_hit = deal_wr_en && (deal_wr_addr != '0)
                      && (deal_wr_addr <= memory_game_pkg::CARD_COUNT);
    assign ctrl_hit = ctrl_wr_en && (ctrl_wr_addr != '0)
                      && (ctrl_wr_addr <= memory_game_pkg::CARD_COUNT);
    assign ctrl_rd_hit = (ctrl_rd_addr != '0)
                         && (ctrl_rd_addr <= memory_game_pkg::CARD_COUNT);
    assign disp_hit = (disp_addr != '0)
                      && (disp_addr <= memory_game_pkg::CARD_COUNT);

    ////////////////////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= memory_game_pkg::CARD_COUNT; i++) begin
                cards[i] <= '0;
            end
        end else if (deal_hit) begin
            // Dealer wins over the control port
            cards[deal_wr_addr] <= deal_wr_data;
        end else if (ctrl_hit) begin
            cards[ctrl_wr_addr] <= ctrl_wr_data;
        end
    end

    // Combinational reads, non-card addresses read as zero
    assign ctrl_rd_data = ctrl_rd_hit ? cards[ctrl_rd_addr] : '0;
    assign disp_data    = disp_hit ? cards[disp_addr] : '0;

endmodule

//--- hw/game_control.sv
`timescale 1ns/1ps

module game_control (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                new_game,
    input  logic                                pick_valid,
    input  logic [memory_game_pkg::ADDR_W-1:0]  pick_card,
    output logic                                pick_ready,
    output logic                                pick_resp_valid,
    output memory_game_pkg::pick_result_t       pick_result,
    output logic [memory_game_pkg::COLOR_W-1:0] pick_color,
    output logic                                deal_start,
    input  logic                                deal_done,
    output logic                                ctrl_wr_en,
    output logic [memory_game_pkg::ADDR_W-1:0]  ctrl_wr_addr,
    output logic [memory_game_pkg::CARD_W-1:0]  ctrl_wr_data,
    output logic [memory_game_pkg::ADDR_W-1:0]  ctrl_rd_addr,
    input  logic [memory_game_pkg::CARD_W-1:0]  ctrl_rd_data,
    output logic                                dealing,
    output logic [2:0]                          pairs,
    output logic [7:0]                          moves,
    output logic                                game_over
);

    memory_game_pkg::ctrl_state_t state;
    memory_game_pkg::pick_result_t resp_result;

    // Accepted pick and its card word
    logic [memory_game_pkg::ADDR_W-1:0]  pick_addr;
    logic [memory_game_pkg::CARD_W-1:0]  card_q;
    logic [memory_game_pkg::COLOR_W-1:0] card_color;
    logic [memory_game_pkg::COLOR_W-1:0] resp_color;
    // First card of the current move
    logic                                pend_valid;
    logic [memory_game_pkg::ADDR_W-1:0]  pend_addr;
    logic [memory_game_pkg::COLOR_W-1:0] pend_color;
    logic                                cover_second;
    logic [memory_game_pkg::ADDR_W-1:0]  cover_addr;
    logic                                start_game;
    logic                                pick_fire;
    logic                                pick_ok;
    logic                                is_match;
    logic [7:0]                          moves_inc;

    ////////////////////////////////////////////////////////////////////////////
    // Pick decode
    ////////////////////////////////////////////////////////////////////////////

    // Hold off a pick that coincides with a restart
    assign pick_ready = (state == memory_game_pkg::S_WAIT_PICK) && !pick_resp_valid
                        && !new_game;
    assign pick_fire  = pick_valid && pick_ready;
    assign start_game = new_game && ((state == memory_game_pkg::S_IDLE)
                        || (state == memory_game_pkg::S_WAIT_PICK));

    assign card_color = card_q[memory_game_pkg::CARD_W-1:memory_game_pkg::COLOR_LSB];
    assign pick_ok    = (pick_addr != '0) && (pick_addr <= memory_game_pkg::CARD_COUNT)
                        && !card_q[memory_game_pkg::CARD_DISC_BIT];
    assign is_match   = pend_valid && (pend_color == card_color);
    // Move counter sticks at 255
    assign moves_inc  = (moves == 8'hFF) ? moves : moves + 8'd1;
    assign cover_addr = cover_second ? pick_addr : pend_addr;

    always_comb begin
        resp_color = pick_ok ? card_color : '0;
        if (!pick_ok) begin
            resp_result = memory_game_pkg::R_REJECT;
        end else if (!pend_valid) begin
            resp_result = memory_game_pkg::R_FIRST;
        end else if (is_match) begin
            resp_result = memory_game_pkg::R_MATCH;
        end else begin
            resp_result = memory_game_pkg::R_MISS;
        end
    end

    // Uncover on respond, read-modify-write to cover again
    always_comb begin
        ctrl_wr_en   = 1'b0;
        ctrl_wr_addr = pick_addr;
        ctrl_wr_data = card_q;
        ctrl_wr_data[memory_game_pkg::CARD_DISC_BIT] = 1'b1;
        ctrl_rd_addr = pick_addr;
        if (state == memory_game_pkg::S_RESPOND) begin
            ctrl_wr_en = pick_ok;
        end else if (state == memory_game_pkg::S_COVER) begin
            ctrl_rd_addr = cover_addr;
            ctrl_wr_en   = 1'b1;
            ctrl_wr_addr = cover_addr;
            ctrl_wr_data = ctrl_rd_data;
            ctrl_wr_data[memory_game_pkg::CARD_DISC_BIT] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM and scoring
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= memory_game_pkg::S_IDLE;
            deal_start      <= 1'b0;
            dealing         <= 1'b0;
            pick_resp_valid <= 1'b0;
            pend_valid      <= 1'b0;
            cover_second    <= 1'b0;
            pairs           <= 3'd0;
            moves           <= 8'd0;
            game_over       <= 1'b0;
        end else begin
            deal_start      <= 1'b0;
            pick_resp_valid <= 1'b0;
            if (start_game) begin
                state      <= memory_game_pkg::S_DEAL;
                deal_start <= 1'b1;
                dealing    <= 1'b1;
                pend_valid <= 1'b0;
                pairs      <= 3'd0;
                moves      <= 8'd0;
                game_over  <= 1'b0;
            end else begin
                case (state)
                    memory_game_pkg::S_DEAL: begin
                        if (deal_done) begin
                            dealing <= 1'b0;
                            state   <= memory_game_pkg::S_WAIT_PICK;
                        end
                    end
                    memory_game_pkg::S_WAIT_PICK: begin
                        if (pick_fire) begin
                            state <= memory_game_pkg::S_READ;
                        end
                    end
                    memory_game_pkg::S_READ: begin
                        state <= memory_game_pkg::S_RESPOND;
                    end
                    memory_game_pkg::S_RESPOND: begin
                        pick_resp_valid <= 1'b1;
                        state           <= memory_game_pkg::S_WAIT_PICK;
                        if (pick_ok && !pend_valid) begin
                            pend_valid <= 1'b1;
                        end else if (pick_ok) begin
                            // Second card closes the move
                            pend_valid <= 1'b0;
                            moves      <= moves_inc;
                            if (is_match) begin
                                pairs <= pairs + 3'd1;
                                if (pairs == 3'(memory_game_pkg::PAIR_COUNT - 1)) begin
                                    game_over <= 1'b1;
                                end
                            end else begin
                                state <= memory_game_pkg::S_COVER;
                            end
                        end
                    end
                    memory_game_pkg::S_COVER: begin
                        // Pending card first, then the picked one
                        cover_second <= !cover_second;
                        if (cover_second) begin
                            state <= memory_game_pkg::S_WAIT_PICK;
                        end
                    end
                    default: begin
                        state <= memory_game_pkg::S_IDLE;
                    end
                endcase
            end
        end
    end

    // Pick payload and response data
    always_ff @(posedge clk) begin
        if (pick_fire) begin
            pick_addr <= pick_card;
        end
        if (state == memory_game_pkg::S_READ) begin
            card_q <= ctrl_rd_data;
        end
        if (state == memory_game_pkg::S_RESPOND) begin
            pick_result <= resp_result;
            pick_color  <= resp_color;
            if (pick_ok && !pend_valid) begin
                pend_addr  <= pick_addr;
                pend_color <= card_color;
            end
        end
    end

endmodule

//--- hw/memory_game_top.sv
`timescale 1ns/1ps

module memory_game_top (
    input  logic                                clk,
    input  logic                                rst,
    // Host pick channel
    input  logic                                new_game,
    input  logic                                pick_valid,
    input  logic [memory_game_pkg::ADDR_W-1:0]  pick_card,
    output logic                                pick_ready,
    output logic                                pick_resp_valid,
    output memory_game_pkg::pick_result_t       pick_result,
    output logic [memory_game_pkg::COLOR_W-1:0] pick_color,
    // Game status
    output logic                                dealing,
    output logic [2:0]                          pairs,
    output logic [7:0]                          moves,
    output logic                                game_over,
    // Display read port
    input  logic [memory_game_pkg::ADDR_W-1:0]  disp_addr,
    output logic [memory_game_pkg::CARD_W-1:0]  disp_data
);

    // Dealer to register file and control
    logic                               deal_start;
    logic                               deal_wr_en;
    logic [memory_game_pkg::ADDR_W-1:0] deal_wr_addr;
    logic [memory_game_pkg::CARD_W-1:0] deal_wr_data;
    logic                               deal_done;

    // Control port of the register file
    logic                               ctrl_wr_en;
    logic [memory_game_pkg::ADDR_W-1:0] ctrl_wr_addr;
    logic [memory_game_pkg::CARD_W-1:0] ctrl_wr_data;
    logic [memory_game_pkg::ADDR_W-1:0] ctrl_rd_addr;
    logic [memory_game_pkg::CARD_W-1:0] ctrl_rd_data;

    card_deal u_card_deal (
        .clk          (clk),
        .rst          (rst),
        .deal_start   (deal_start),
        .deal_wr_en   (deal_wr_en),
        .deal_wr_addr (deal_wr_addr),
        .deal_wr_data (deal_wr_data),
        .deal_done    (deal_done)
    );

    card_regfile u_card_regfile (
        .clk          (clk),
        .rst          (rst),
        .deal_wr_en   (deal_wr_en),
        .deal_wr_addr (deal_wr_addr),
        .deal_wr_data (deal_wr_data),
        .ctrl_wr_en   (ctrl_wr_en),
        .ctrl_wr_addr (ctrl_wr_addr),
        .ctrl_wr_data (ctrl_wr_data),
        .ctrl_rd_addr (ctrl_rd_addr),
        .ctrl_rd_data (ctrl_rd_data),
        .disp_addr    (disp_addr),
        .disp_data    (disp_data)
    );

    game_control u_game_control (
        .clk             (clk),
        .rst             (rst),
        .new_game        (new_game),
        .pick_valid      (pick_valid),
        .pick_card       (pick_card),
        .pick_ready      (pick_ready),
        .pick_resp_valid (pick_resp_valid),
        .pick_result     (pick_result),
        .pick_color      (pick_color),
        .deal_start      (deal_start),
        .deal_done       (deal_done),
        .ctrl_wr_en      (ctrl_wr_en),
        .ctrl_wr_addr    (ctrl_wr_addr),
        .ctrl_wr_data    (ctrl_wr_data),
        .ctrl_rd_addr    (ctrl_rd_addr),
        .ctrl_rd_data    (ctrl_rd_data),
        .dealing         (dealing),
        .pairs           (pairs),
        .moves           (moves),
        .game_over       (game_over)
    );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset spans five rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- verification/memory_game_assert.sv
`timescale 1ns/1ps

module memory_game_assert (
    input logic       clk,
    input logic       rst,
    input logic       pick_ready,
    input logic       pick_resp_valid,
    input logic       dealing,
    input logic [2:0] pairs,
    input logic       game_over
);

    // No pick is taken while the board is being dealt
    ready_not_dealing: assert property (@(posedge clk) disable iff (rst)
        !(pick_ready && dealing))
        else $error("pick_ready high during a deal");

    // Response strobe lasts one cycle
    resp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        pick_resp_valid |=> !pick_resp_valid)
        else $error("pick_resp_valid held for more than one cycle");

    // Six pairs on the board at most
    pairs_in_range: assert property (@(posedge clk) disable iff (rst)
        pairs <= memory_game_pkg::PAIR_COUNT)
        else $error("pairs counter above the pair count");

    // Game over only with every pair found
    over_means_all_pairs: assert property (@(posedge clk) disable iff (rst)
        game_over |-> (pairs == memory_game_pkg::PAIR_COUNT))
        else $error("game_over without all pairs found");

endmodule

bind game_control memory_game_assert u_memory_game_assert (.*);

//--- verification/memory_game_tb.sv
`timescale 1ns/1ps

module memory_game_tb;

    logic clk;
    logic rst;
    logic new_game;
    logic pick_valid;
    logic [memory_game_pkg::ADDR_W-1:0] pick_card;
    logic pick_ready;
    logic pick_resp_valid;
    memory_game_pkg::pick_result_t pick_result;
    logic [memory_game_pkg::COLOR_W-1:0] pick_color;
    logic dealing;
    logic [2:0] pairs;
    logic [7:0] moves;
    logic game_over;
    logic [memory_game_pkg::ADDR_W-1:0] disp_addr;
    logic [memory_game_pkg::CARD_W-1:0] disp_data;

    // Board model for slots 1 to 12
    logic [3:0] m_shuffle;
    logic [memory_game_pkg::COLOR_W-1:0] m_color [1:memory_game_pkg::CARD_COUNT];
    logic m_disc [1:memory_game_pkg::CARD_COUNT];
    logic m_pend_valid;
    int m_pend;
    int m_pairs;
    int m_moves;

    logic [31:0] lfsr = 32'h7acb;
    int cycle_count = 0;
    // At most 80 picks at 20 cycles each plus 100 per game for reset and deal
    int cycle_limit = 20 * 80 + 100 * 2;

    tb_clock u_tb_clock (.clk (clk), .rst (rst));

    memory_game_top u_memory_game_top (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [11:0] colour_of(input int idx);
        case (idx)
            0: return memory_game_pkg::COLOR_GREEN;
            1: return memory_game_pkg::COLOR_YELLOW;
            2: return memory_game_pkg::COLOR_RED;
            3: return memory_game_pkg::COLOR_BLUE;
            4: return memory_game_pkg::COLOR_MAGENTA;
            default: return memory_game_pkg::COLOR_MINT;
        endcase
    endfunction

    // Next covered card or the partner of the pending one
    function automatic int guided_card();
        for (int a = 1; a <= memory_game_pkg::CARD_COUNT; a++) begin
            if (!m_disc[a] && (!m_pend_valid || m_color[a] == m_color[m_pend])) begin
                return a;
            end
        end
        return 0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Model updates and checks

    // Shuffle walks on from where the last deal stopped
    task automatic model_deal();
        logic [3:0] v;
        int slot;
        slot = 1;
        while (slot <= memory_game_pkg::CARD_COUNT) begin
            v = m_shuffle;
            m_shuffle = m_shuffle >> 1;
            m_shuffle[3] = v[0] ^ v[1];
            if (v >= 1 && v <= 12) begin
                m_color[slot] = colour_of((int'(v) - 1) / 2);
                m_disc[slot] = 1'b0;
                slot++;
            end
        end
        m_pend_valid = 1'b0;
        m_pairs = 0;
        m_moves = 0;
    endtask

    // One slot per cycle, sampled on the following falling edge
    task automatic check_display();
        for (int a = 1; a <= memory_game_pkg::CARD_COUNT; a++) begin
            disp_addr = a[3:0];
            @(negedge clk);
            compare($sformatf("disp_data[%0d]", a), disp_data,
                    {m_color[a], m_disc[a], 1'b1});
        end
    endtask

    task automatic check_score();
        compare("pairs", pairs, m_pairs);
        compare("moves", moves, m_moves);
        compare("game_over", game_over, m_pairs == memory_game_pkg::PAIR_COUNT);
    endtask

    task automatic start_game();
        new_game = 1'b1;
        @(negedge clk);
        new_game = 1'b0;
        compare("dealing", dealing, 1);
        model_deal();
        while (dealing) @(negedge clk);
        check_score();
        check_display();
    endtask

    task automatic do_pick(input int card);
        memory_game_pkg::pick_result_t exp_res;
        logic [11:0] exp_col;
        int lat;
        exp_res = memory_game_pkg::R_REJECT;
        exp_col = '0;
        // Expected outcome from the pick rules
        if (card >= 1 && card <= 12) begin
            if (!m_disc[card]) begin
                m_disc[card] = 1'b1;
                exp_col = m_color[card];
                if (!m_pend_valid) begin
                    exp_res = memory_game_pkg::R_FIRST;
                    m_pend_valid = 1'b1;
                    m_pend = card;
                end else begin
                    m_pend_valid = 1'b0;
                    m_moves = (m_moves == 255) ? 255 : m_moves + 1;
                    if (m_color[m_pend] == m_color[card]) begin
                        exp_res = memory_game_pkg::R_MATCH;
                        m_pairs++;
                    end else begin
                        // Both cards go face down again
                        exp_res = memory_game_pkg::R_MISS;
                        m_disc[m_pend] = 1'b0;
                        m_disc[card] = 1'b0;
                    end
                end
            end
        end
        pick_valid = 1'b1;
        pick_card = card[3:0];
        while (!pick_ready) @(negedge clk);
        // Accepted on the next rising edge
        @(negedge clk);
        pick_valid = 1'b0;
        lat = 0;
        while (!pick_resp_valid) begin
            @(negedge clk);
            lat++;
        end
        compare("pick_latency", lat, 2);
        compare("pick_result", pick_result, exp_res);
        compare("pick_color", pick_color, exp_col);
        // After a miss this also covers the re-cover cycles
        while (!pick_ready) @(negedge clk);
        check_score();
        check_display();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and timeout

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        new_game = 1'b0;
        pick_valid = 1'b0;
        pick_card = '0;
        disp_addr = '0;
        m_shuffle = memory_game_pkg::SHUFFLE_SEED;
        @(negedge rst);
        @(negedge clk);
        compare("pick_ready", pick_ready, 0);
        compare("dealing", dealing, 0);
        start_game();
        // Addresses that are not cards
        do_pick(0);
        do_pick(13);
        do_pick(14);
        do_pick(15);
        repeat (40) do_pick(random_bits(4));
        while (m_pairs < memory_game_pkg::PAIR_COUNT) do_pick(guided_card());
        // Any card is rejected once the whole board is discovered
        repeat (2) do_pick(random_bits(4) % 12 + 1);
        // Second game continues the shuffle sequence
        start_game();
        repeat (10) do_pick(random_bits(4));
        while (m_pairs < memory_game_pkg::PAIR_COUNT) do_pick(guided_card());
        $display("Everything OK");
        $finish;
    end

endmodule

//--- build.f
hw/memory_game_pkg.sv
hw/card_deal.sv
hw/card_regfile.sv
hw/game_control.sv
hw/memory_game_top.sv
verification/tb_clock.sv
verification/memory_game_assert.sv
verification/memory_game_tb.sv
